/* hdl/sched_settings.svh */
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

`default_nettype none

// ##############################
// instruction field widths
// ##############################

// program counter.
`define SCHED_PC_W      32

// packed decoded opcode of the main stream.
`define SCHED_OPCODE_W  17

// register index where x0 is the zero register.
`define SCHED_REG_W     5

// csr address.
`define SCHED_CSR_W     12

// immediate value.
`define SCHED_IMM_W     32

`default_nettype wire

`endif

/* hdl/sched_pkg.sv */
`include "sched_settings.svh"
`default_nettype none

package sched_pkg;

    // ##############################
    // field types
    // ##############################

    typedef logic [`SCHED_PC_W-1:0]     pc_t;
    typedef logic [`SCHED_OPCODE_W-1:0] opcode_t;
    typedef logic [`SCHED_REG_W-1:0]    reg_idx_t;
    typedef logic [`SCHED_CSR_W-1:0]    csr_addr_t;
    typedef logic [`SCHED_IMM_W-1:0]    imm_t;

    // ##############################
    // instruction records
    // ##############################

    // full decoded instruction of the main stream.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        opcode_t   opcode;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        csr_addr_t csr;
        imm_t      imm;
    } main_op_t;

    // coprocessor stream.
    // only the pc and the register indices travel with it.
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } cop_op_t;

endpackage

`default_nettype wire

/* hdl/main_slot.sv */
`default_nettype none

module main_slot
    import sched_pkg::*;
    (
        // clock and reset
        input  logic     CLK,
        input  logic     rst_n,

        // from decode
        input  main_op_t a_in,

        // from the issue arbiter
        input  logic     freeze,
        input  logic     flush_slots,
        input  logic     defer,

        // to the issue arbiter
        output main_op_t slot_a
    );

    // ##############################
    // next entry
    // ##############################

    main_op_t entry_q;
    main_op_t entry_d;

    // flush beats freeze, freeze beats defer.
    always_comb begin
        if (flush_slots) begin
            entry_d = '0;
        end
        else if (freeze) begin
            entry_d = entry_q;
        end
        else if (defer) begin
            // main op already went out alone this cycle,
            // so the slot drops to empty while decode holds.
            entry_d = '0;
        end
        else begin
            entry_d = a_in;
        end
    end

    // ##############################
    // holding register
    // ##############################

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            entry_q <= '0;
        end
        else begin
            entry_q <= entry_d;
        end
    end

    // registered entry goes straight to the arbiter.
    assign slot_a = entry_q;

endmodule

`default_nettype wire

/* hdl/cop_slot.sv */
`default_nettype none

module cop_slot
    import sched_pkg::*;
    (
        input  logic    CLK,
        input  logic    rst_n,

        // from decode
        input  cop_op_t b_in,

        // slot control
        input  logic    freeze,
        input  logic    flush_slots,
        input  logic    defer,

        output cop_op_t slot_b
    );

    cop_op_t entry_q;
    cop_op_t entry_d;

    // ##############################
    // next entry
    // ##############################

    // defer keeps the blocked op for a retry next cycle.
    always_comb begin
        if (flush_slots) begin
            entry_d = '0;
        end
        else if (freeze || defer) begin
            entry_d = entry_q;
        end
        else begin
            entry_d = b_in;
        end
    end

    // ##############################
    // holding register
    // ##############################

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            entry_q <= '0;
        end
        else begin
            entry_q <= entry_d;
        end
    end

    assign slot_b = entry_q;

endmodule

`default_nettype wire

/* hdl/issue_arbiter.sv */
`default_nettype none

module issue_arbiter
    import sched_pkg::*;
    (
        // pipeline control levels
        input  logic     STALL,
        input  logic     MEM_WAIT,
        input  logic     FLUSH,

        // registered slot contents
        input  main_op_t slot_a,
        input  cop_op_t  slot_b,

        // slot control
        output logic     freeze,
        output logic     flush_slots,
        output logic     defer,

        // back-pressure to decode
        output logic     busy,

        // to execute
        output main_op_t sched_a,
        output cop_op_t  sched_b,
        output logic     a_allow,
        output logic     b_allow
    );

    // ##############################
    // dependency check
    // ##############################

    reg_idx_t a_rd;
    logic     a_rd_live;
    logic     hit_rs1;
    logic     hit_rs2;
    logic     hit_rd;
    logic     both_valid;
    logic     dep;

    assign a_rd = slot_a.rd;

    // writes to x0 are discarded, never a hazard.
    assign a_rd_live = (a_rd != '0);

    assign hit_rs1 = (a_rd == slot_b.rs1);
    assign hit_rs2 = (a_rd == slot_b.rs2);
    // write-after-write on the same register counts too.
    assign hit_rd  = (a_rd == slot_b.rd);

    assign both_valid = slot_a.valid && slot_b.valid;

    assign dep = both_valid && a_rd_live && (hit_rs1 || hit_rs2 || hit_rd);

    // ##############################
    // slot control
    // ##############################

    assign freeze      = STALL || MEM_WAIT;
    assign flush_slots = FLUSH;

    // no deferral while frozen.
    // the pair just sits until the freeze lifts.
    assign defer = dep && !freeze;

    // decode holds its inputs for exactly the deferral cycle.
    assign busy = defer;

    // ##############################
    // issue
    // ##############################

    assign sched_a = slot_a;
    assign sched_b = slot_b;

    // main op never waits on the coprocessor op.
    assign a_allow = slot_a.valid;

    // b goes out only when clear of the main op.
    assign b_allow = slot_b.valid && !dep;

endmodule

`default_nettype wire

/* hdl/schedule.sv */
`default_nettype none

module schedule
    import sched_pkg::*;
    (
        // clock and reset
        input  logic     CLK,
        input  logic     rst_n,

        // pipeline control
        input  logic     STALL,
        input  logic     MEM_WAIT,
        input  logic     FLUSH,

        // decode side
        input  main_op_t a_in,
        input  cop_op_t  b_in,
        output logic     busy,

        // execute side
        output main_op_t sched_a,
        output cop_op_t  sched_b,
        output logic     a_allow,
        output logic     b_allow
    );

    // ##############################
    // internal wires
    // ##############################

    main_op_t slot_a;
    cop_op_t  slot_b;
    logic     freeze;
    logic     flush_slots;
    logic     defer;

    // ##############################
    // slots
    // ##############################

    main_slot u_main_slot (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .a_in        (a_in),
        .freeze      (freeze),
        .flush_slots (flush_slots),
        .defer       (defer),
        .slot_a      (slot_a)
    );

    cop_slot u_cop_slot (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .b_in        (b_in),
        .freeze      (freeze),
        .flush_slots (flush_slots),
        .defer       (defer),
        .slot_b      (slot_b)
    );

    // dependency and control decisions all live here.
    issue_arbiter u_issue_arbiter (
        .STALL       (STALL),
        .MEM_WAIT    (MEM_WAIT),
        .FLUSH       (FLUSH),
        .slot_a      (slot_a),
        .slot_b      (slot_b),
        .freeze      (freeze),
        .flush_slots (flush_slots),
        .defer       (defer),
        .busy        (busy),
        .sched_a     (sched_a),
        .sched_b     (sched_b),
        .a_allow     (a_allow),
        .b_allow     (b_allow)
    );

endmodule

`default_nettype wire

/* verif/schedule_props.sv */
`default_nettype none

module schedule_props
    import sched_pkg::*;
    (
        input logic    CLK,
        input logic    rst_n,
        input logic    STALL,
        input logic    MEM_WAIT,
        input logic    FLUSH,
        input logic    busy,
        input logic    b_allow,
        input cop_op_t sched_b
    );

    timeunit 1ns;
    timeprecision 1ps;

    // ##############################
    // issue rules
    // ##############################

    // b only issues with a valid entry.
    b_allow_needs_valid: assert property (
        @(posedge CLK) disable iff (!rst_n) b_allow |-> sched_b.valid
    ) else $error("b_allow is high with an empty coprocessor entry");

    // no deferral while frozen.
    busy_not_frozen: assert property (
        @(posedge CLK) disable iff (!rst_n) busy |-> (!STALL && !MEM_WAIT)
    ) else $error("busy is high during a stall or memory wait");

    // the deferred op always goes out on the retry cycle.
    busy_then_retry: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (busy && !FLUSH && !STALL && !MEM_WAIT) |=> b_allow
    ) else $error("deferred coprocessor op did not issue on the next cycle");

endmodule

bind schedule schedule_props u_schedule_props (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .STALL    (STALL),
    .MEM_WAIT (MEM_WAIT),
    .FLUSH    (FLUSH),
    .busy     (busy),
    .b_allow  (b_allow),
    .sched_b  (sched_b)
);

`default_nettype wire

/* verif/schedule_tb.sv */
`include "sched_settings.svh"
`default_nettype none

module schedule_tb
    import sched_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_CYCLES  = 3000;
    localparam int          RESET_LIMIT = 50;
    localparam int          DRAIN_LIMIT = 20;
    localparam logic [31:0] LFSR_SEED   = 32'h4ed3f680;

    logic     CLK = 1'b0;
    logic     rst_n;
    logic     STALL;
    logic     MEM_WAIT;
    logic     FLUSH;
    main_op_t a_in;
    cop_op_t  b_in;
    logic     busy;
    main_op_t sched_a;
    cop_op_t  sched_b;
    logic     a_allow;
    logic     b_allow;

    // values on the DUT inputs during the current cycle.
    main_op_t cur_a;
    cop_op_t  cur_b;
    logic     cur_stall;
    logic     cur_mw;
    logic     cur_flush;

    // expected slot contents.
    main_op_t exp_a;
    cop_op_t  exp_b;

    logic [31:0] lfsr;
    int          n_defer;
    int          n_freeze;
    int          n_flush;

    schedule UUT (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .STALL    (STALL),
        .MEM_WAIT (MEM_WAIT),
        .FLUSH    (FLUSH),
        .a_in     (a_in),
        .b_in     (b_in),
        .busy     (busy),
        .sched_a  (sched_a),
        .sched_b  (sched_b),
        .a_allow  (a_allow),
        .b_allow  (b_allow)
    );

    always #20 CLK = ~CLK;

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge CLK);
        rst_n <= 1'b1;
    end

    // ##############################
    // random source
    // ##############################

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // register indices from x0..x3 so hazards show up often.
    function automatic main_op_t draw_main();
        main_op_t op;
        op.valid  = (draw_bits(2) != 0);
        op.pc     = pc_t'(draw_bits(`SCHED_PC_W));
        op.opcode = opcode_t'(draw_bits(`SCHED_OPCODE_W));
        op.rd     = reg_idx_t'(draw_bits(2));
        op.rs1    = reg_idx_t'(draw_bits(2));
        op.rs2    = reg_idx_t'(draw_bits(2));
        op.csr    = csr_addr_t'(draw_bits(`SCHED_CSR_W));
        op.imm    = imm_t'(draw_bits(`SCHED_IMM_W));
        return op;
    endfunction

    function automatic cop_op_t draw_cop();
        cop_op_t op;
        op.valid = (draw_bits(2) != 0);
        op.pc    = pc_t'(draw_bits(`SCHED_PC_W));
        op.rd    = reg_idx_t'(draw_bits(2));
        op.rs1   = reg_idx_t'(draw_bits(2));
        op.rs2   = reg_idx_t'(draw_bits(2));
        return op;
    endfunction

    // ##############################
    // reference model and checks
    // ##############################

    // main rd other than x0 against any coprocessor index.
    function automatic logic has_dep(input main_op_t a, input cop_op_t b);
        logic hit;
        hit = (a.rd == b.rs1) || (a.rd == b.rs2) || (a.rd == b.rd);
        return a.valid && b.valid && (a.rd != '0) && hit;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_main(input string name, input main_op_t exp_v, input main_op_t act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v));
        end
    endtask

    task automatic compare_cop(input string name, input cop_op_t exp_v, input cop_op_t act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("ERR t=%0t %s expected=%b actual=%b", $time, name, exp_v, act_v));
        end
    endtask

    task automatic check_outputs();
        logic dep;
        dep = has_dep(exp_a, exp_b);
        compare_main("sched_a", exp_a, sched_a);
        compare_cop("sched_b", exp_b, sched_b);
        compare_bit("a_allow", exp_a.valid, a_allow);
        compare_bit("b_allow", exp_b.valid && !dep, b_allow);
        compare_bit("busy", dep && !(cur_stall || cur_mw), busy);
    endtask

    // one clock of model step, new stimulus and a check at the falling edge.
    task automatic run_cycle(input logic active);
        logic frz;
        logic dfr;
        @(posedge CLK);
        frz = cur_stall || cur_mw;
        dfr = has_dep(exp_a, exp_b) && !frz;
        if (cur_flush) begin
            exp_a = '0;
            exp_b = '0;
            n_flush++;
        end
        else if (frz) begin
            n_freeze++;
        end
        else if (dfr) begin
            exp_a = '0;
            n_defer++;
        end
        else begin
            exp_a = cur_a;
            exp_b = cur_b;
        end
        // decode holds its pair across a deferral.
        if (!dfr) begin
            cur_a = active ? draw_main() : '0;
            cur_b = active ? draw_cop() : '0;
        end
        cur_stall = active && (draw_bits(4) == 0);
        cur_mw    = active && (draw_bits(4) == 0);
        cur_flush = active && (draw_bits(5) == 0);
        a_in     <= cur_a;
        b_in     <= cur_b;
        STALL    <= cur_stall;
        MEM_WAIT <= cur_mw;
        FLUSH    <= cur_flush;
        @(negedge CLK);
        check_outputs();
    endtask

    // ##############################
    // main sequence
    // ##############################

    initial begin
        int wait_cnt;
        lfsr      = LFSR_SEED;
        cur_a     = '0;
        cur_b     = '0;
        cur_stall = 1'b0;
        cur_mw    = 1'b0;
        cur_flush = 1'b0;
        exp_a     = '0;
        exp_b     = '0;
        n_defer   = 0;
        n_freeze  = 0;
        n_flush   = 0;
        a_in      = '0;
        b_in      = '0;
        STALL     = 1'b0;
        MEM_WAIT  = 1'b0;
        FLUSH     = 1'b0;

        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(posedge CLK);
            wait_cnt++;
            if (wait_cnt > RESET_LIMIT) begin
                abort_run("reset was never released");
            end
        end
        // empty slots, allows and busy low out of reset.
        @(negedge CLK);
        check_outputs();

        repeat (NUM_CYCLES) run_cycle(1'b1);

        wait_cnt = 0;
        while (sched_a.valid || sched_b.valid || cur_a.valid || cur_b.valid) begin
            run_cycle(1'b0);
            wait_cnt++;
            if (wait_cnt > DRAIN_LIMIT) begin
                abort_run("the stage did not drain after the stimulus ended");
            end
        end

        if (n_defer == 0 || n_freeze == 0 || n_flush == 0) begin
            abort_run("the stimulus never hit a deferral, a freeze or a flush");
        end
        else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* schedule.f */
+incdir+hdl
hdl/sched_pkg.sv
hdl/main_slot.sv
hdl/cop_slot.sv
hdl/issue_arbiter.sv
hdl/schedule.sv
verif/schedule_props.sv
verif/schedule_tb.sv

/* Makefile */
TOP := schedule_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f schedule.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
